/* dataMmu_stim.txt */
# W idx vpn2 asid g pfn0 c0 d0 v0 pfn1 c1 d1 v1 (TLB write), F (buffer flush)
# A R|W asid vaddr, then expected paddr cached valid exc miss; all fields hex
W 0 00200 05 0 12345 3 1 1 23456 2 0 1
W 1 00300 05 0 00111 3 1 0 00222 3 0 1
W 2 00400 07 1 0aaaa 3 1 1 0bbbb 0 1 1
A R 05 80001234 00001234 1 1 0 0
A W 05 9ffffffc 1ffffffc 1 1 0 0
A W 05 a0005678 00005678 0 1 0 0
A R 05 bfc00000 1fc00000 0 1 0 0
A R 05 00400abc 12345abc 1 1 0 1
A W 05 00401def 23456def 0 0 5 0
A R 05 00401def 23456def 0 1 0 0
A R 05 00600123 00111123 1 0 3 1
A W 05 00600123 00111123 1 0 4 0
A R 05 00601456 00222456 1 1 0 0
A R 05 00a00000 00000000 0 0 1 1
A W 09 00400010 00000000 0 0 2 1
A R 09 00800040 0aaaa040 1 1 0 1
F
A R 09 00800040 0aaaa040 1 1 0 1
W 2 00400 07 1 0cccc 0 1 1 0dddd 0 1 1
A R 09 00801040 0dddd040 0 1 0 1

/* all.f */
+incdir+.
tlbTypesPkg.sv
memAccessPkg.sv
tlbArray.sv
dataTlbBuffer.sv
dataMmu.sv
tbClock.sv
dataMmu_properties.sv
dataMmuTb.sv

/* run.sh */
#!/bin/sh
# compile and run the data MMU testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module dataMmuTb &&
./obj_dir/VdataMmuTb | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* dataMmuTb.sv */
// data MMU testbench: reads TLB writes, flushes and accesses from the stim file
// drives the DUT, checks translation results and stall counts, runs a timeout

`timescale 1ns/1ns
`include "mmu_consts.svh"

module dataMmuTb;
    import tlbTypesPkg::*;
    import memAccessPkg::*;

    logic                    clk;
    logic                    rstN;
    memReqT                  req;
    logic [7:0]              asid;
    logic                    flush;
    logic                    tlbWe;
    logic [`TLB_INDEX_W-1:0] tlbWIndex;
    tlbEntryT                tlbWEntry;
    xlateResT                res;
    logic                    stall;

    string lines[$];
    int    cycleCount = 0;
    int    cycleLimit = 100000;  // replaced once the stim file is read

    tbClock uTbClock (
        .clk (clk),
        .rstN(rstN)
    );

    dataMmu u_dataMmu (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .asid     (asid),
        .flush    (flush),
        .tlbWe    (tlbWe),
        .tlbWIndex(tlbWIndex),
        .tlbWEntry(tlbWEntry),
        .res      (res),
        .stall    (stall)
    );

    bind dataMmu dataMmu_properties uDataMmuProps (
        .clk  (clk),
        .rstN (rstN),
        .req  (req),
        .res  (res),
        .stall(stall)
    );

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("timeout: run passed %0d clock cycles", cycleLimit));
        end
    end

    task automatic writeTlb(input string args);
        int                      n;
        logic [`TLB_INDEX_W-1:0] idx;
        logic [18:0]             vpn2;
        logic [7:0]              entAsid;
        logic                    g;
        logic [19:0]             pfn0;
        logic [19:0]             pfn1;
        logic [2:0]              c0;
        logic [2:0]              c1;
        logic                    d0;
        logic                    d1;
        logic                    v0;
        logic                    v1;
        n = $sscanf(args, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    idx, vpn2, entAsid, g, pfn0, c0, d0, v0, pfn1, c1, d1, v1);
        assert (n == 12) else stopWithFailure("malformed TLB write line in stim file");
        @(posedge clk);
        #1;
        req                = '0;
        tlbWe              = 1'b1;
        tlbWIndex          = idx;
        tlbWEntry.vpn2     = vpn2;
        tlbWEntry.asid     = entAsid;
        tlbWEntry.g        = g;
        tlbWEntry.page[0]  = '{pfn: pfn0, c: c0, d: d0, v: v0};
        tlbWEntry.page[1]  = '{pfn: pfn1, c: c1, d: d1, v: v1};
        @(posedge clk);
        #1;
        tlbWe = 1'b0;
    endtask

    task automatic flushBuffer();
        @(posedge clk);
        #1;
        req   = '0;
        flush = 1'b1;  // one-cycle strobe
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic runAccess(input byte op, input string args);
        int          n;
        int          stallCycles;
        int          expStall;
        logic [7:0]  accAsid;
        logic [31:0] vaddr;
        logic [31:0] expPaddr;
        logic        expCached;
        logic        expValid;
        logic [2:0]  expExc;
        logic        expMiss;
        n = $sscanf(args, "%h %h %h %h %h %h %h",
                    accAsid, vaddr, expPaddr, expCached, expValid, expExc, expMiss);
        assert (n == 7) else stopWithFailure("malformed access line in stim file");
        @(posedge clk);
        #1;
        req.rd    = (op == "R");
        req.wr    = (op == "W");
        req.vaddr = vaddr;
        asid      = accAsid;
        stallCycles = 0;
        @(negedge clk);  // outputs settled mid-cycle
        while (stall) begin
            stallCycles++;
            assert (stallCycles <= 2) else stopWithFailure($sformatf(
                "[FAIL] %0t: stall longer than two cycles, vaddr %h", $time, vaddr));
            @(negedge clk);
        end
        expStall = expMiss ? 2 : 0;
        assert (stallCycles == expStall) else stopWithFailure($sformatf(
            "[FAIL] %0t: vaddr %h stalled %0d cycles, expected %0d",
            $time, vaddr, stallCycles, expStall));
        assert (res.valid == expValid) else stopWithFailure($sformatf(
            "[FAIL] %0t: vaddr %h valid %b, expected %b", $time, vaddr, res.valid, expValid));
        assert (3'(res.exc) == expExc) else stopWithFailure($sformatf(
            "[FAIL] %0t: vaddr %h exception %0d, expected %0d",
            $time, vaddr, 3'(res.exc), expExc));
        if (expValid) begin
            assert (res.paddr == expPaddr) else stopWithFailure($sformatf(
                "[FAIL] %0t: vaddr %h paddr %h, expected %h", $time, vaddr, res.paddr, expPaddr));
            assert (res.cached == expCached) else stopWithFailure($sformatf(
                "[FAIL] %0t: vaddr %h cached %b, expected %b",
                $time, vaddr, res.cached, expCached));
        end
    endtask

    initial begin
        int    fd;
        int    idle;
        byte   kind;
        string line;
        req       = '0;
        asid      = '0;
        flush     = 1'b0;
        tlbWe     = 1'b0;
        tlbWIndex = '0;
        tlbWEntry = '0;
        void'($urandom(32'hab40));
        fd = $fopen("dataMmu_stim.txt", "r");
        if (fd == 0) begin
            stopWithFailure("could not open stimulus file dataMmu_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                if (kind != "#" && kind != "\n" && kind != " " && line.len() > 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = 20 * lines.size() + 10;  // plus reset
        wait (rstN);
        foreach (lines[i]) begin
            kind = lines[i].getc(0);
            case (kind)
                "W": writeTlb(lines[i].substr(2, lines[i].len() - 1));
                "F": flushBuffer();
                "A": begin
                    runAccess(lines[i].getc(2), lines[i].substr(4, lines[i].len() - 1));
                    idle = $urandom % 4;
                    repeat (idle) begin
                        @(posedge clk);
                        #1;
                        req = '0;
                    end
                end
                default: stopWithFailure("unknown line type in stimulus file");
            endcase
        end
        @(posedge clk);
        #1;
        req = '0;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* dataMmu_properties.sv */
// concurrent checks on the data MMU stall and translation result

`timescale 1ns/1ns

module dataMmu_properties (
    input logic                   clk,
    input logic                   rstN,
    input memAccessPkg::memReqT   req,
    input memAccessPkg::xlateResT res,
    input logic                   stall
);
    import memAccessPkg::*;

    // a buffer miss costs two stall cycles, never more
    stallBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        (stall && $past(stall)) |=> !stall
    ) else $error("stall held high for more than two cycles");

    validNoExc: assert property (
        @(posedge clk) disable iff (!rstN)
        !(res.valid && (res.exc != NONE))
    ) else $error("result valid together with a TLB exception");

    // idle cycles never stall
    noStallIdle: assert property (
        @(posedge clk) disable iff (!rstN)
        !(req.rd || req.wr) |-> !stall
    ) else $error("stall high with no access requested");

endmodule

/* tbClock.sv */
// testbench clock (10 ns period) and active-low reset for 10 cycles

`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstN = 1'b1;  // release just after the edge
    end

endmodule

/* dataMmu.sv */
// data MMU top: TLB buffer in front of the joint TLB

`timescale 1ns/1ns
`include "mmu_consts.svh"

module dataMmu (
    input  logic                    clk,
    input  logic                    rstN,
    input  memAccessPkg::memReqT    req,
    input  logic [7:0]              asid,
    input  logic                    flush,
    input  logic                    tlbWe,
    input  logic [`TLB_INDEX_W-1:0] tlbWIndex,
    input  tlbTypesPkg::tlbEntryT   tlbWEntry,
    output memAccessPkg::xlateResT  res,
    output logic                    stall
);
    import tlbTypesPkg::*;

    logic [18:0] searchVpn2;
    tlbEntryT    searchEntry;
    logic        searchFound;

    tlbArray uTlbArray (
        .clk        (clk),
        .rstN       (rstN),
        .we         (tlbWe),
        .wIndex     (tlbWIndex),
        .wEntry     (tlbWEntry),
        .asid       (asid),
        .searchVpn2 (searchVpn2),
        .searchEntry(searchEntry),
        .searchFound(searchFound)
    );

    dataTlbBuffer uDataTlbBuffer (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .asid       (asid),
        .flush      (flush),
        .tlbWe      (tlbWe),  // any write flushes the buffer
        .searchEntry(searchEntry),
        .searchFound(searchFound),
        .searchVpn2 (searchVpn2),
        .res        (res),
        .stall      (stall)
    );

endmodule

/* dataTlbBuffer.sv */
// one-entry data TLB buffer with IDLE/SEARCH refill FSM
// segment decode, address translation, cache attribute and TLB exceptions

`timescale 1ns/1ns
`include "mmu_consts.svh"

module dataTlbBuffer (
    input  logic                   clk,
    input  logic                   rstN,
    input  memAccessPkg::memReqT   req,
    input  logic [7:0]             asid,
    input  logic                   flush,
    input  logic                   tlbWe,
    input  tlbTypesPkg::tlbEntryT  searchEntry,
    input  logic                   searchFound,
    output logic [18:0]            searchVpn2,
    output memAccessPkg::xlateResT res,
    output logic                   stall
);
    import tlbTypesPkg::*;
    import memAccessPkg::*;

    typedef enum logic {
        IDLE,
        SEARCH
    } stateE;

    localparam logic [31:0] Kseg1Base = `KSEG1_BASE;
    localparam logic [2:0]  Kseg1Seg  = Kseg1Base[31:29];

    stateE                     state;
    stateE                     nextState;
    bufEntryT                  buffer;
    bufEntryT                  fillEntry;
    logic                      bufFilled;
    logic                      bufFlush;
    logic [31:0]               vaddrRaw;
    logic                      access;
    logic                      unmapped;
    logic                      isKseg1;
    logic                      bufHit;
    pageAttrT                  page;
    logic [`PAGE_OFFSET_W-1:0] pageOffset;
    logic [31:0]               paddr;
    logic                      cached;
    logic                      valid;
    tlbExcE                    exc;

    assign bufFlush   = flush | tlbWe;  // a TLB write may touch the buffered entry
    assign vaddrRaw   = req.vaddr;
    assign access     = req.rd | req.wr;
    assign unmapped   = (vaddrRaw >= `KSEG0_BASE) && (vaddrRaw < `KSEG2_BASE);
    assign isKseg1    = (req.vaddr.segView.seg == Kseg1Seg);
    assign searchVpn2 = req.vaddr.pageView.vpn2;

    assign bufHit = bufFilled
                    && (buffer.entry.vpn2 == req.vaddr.pageView.vpn2)
                    && (buffer.entry.asid == asid);
    assign stall  = access && !unmapped && !bufHit;

    // one SEARCH cycle per miss, then back to IDLE
    always_comb begin
        nextState = IDLE;
        if (state == IDLE && stall) begin
            nextState = SEARCH;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else if (bufFlush) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // tag with the requesting vpn2/asid, not the matched entry's
    always_comb begin
        fillEntry            = '{entry: searchEntry, found: searchFound};
        fillEntry.entry.vpn2 = req.vaddr.pageView.vpn2;
        fillEntry.entry.asid = asid;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bufFilled <= 1'b0;
        end else if (bufFlush) begin
            bufFilled <= 1'b0;
        end else if (state == SEARCH) begin
            bufFilled <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEARCH) begin
            buffer <= fillEntry;  // captured at end of cycle 1
        end
    end

    assign page       = buffer.entry.page[req.vaddr.pageView.odd];
    assign pageOffset = req.vaddr.pageView.offset;

    always_comb begin
        if (unmapped) begin
            paddr  = vaddrRaw - (isKseg1 ? `KSEG1_BASE : `KSEG0_BASE);
            cached = !isKseg1;  // kseg0 cached, kseg1 not
        end else begin
            paddr  = {page.pfn, pageOffset};
            cached = (page.c == `CACHE_ATTR_CACHED);
        end
    end

    always_comb begin
        valid = 1'b0;
        exc   = NONE;
        if (!access) begin
            valid = 1'b0;  // idle cycle
        end else if (unmapped) begin
            valid = 1'b1;
        end else if (!bufHit) begin
            valid = 1'b0;  // stalled for refill
        end else if (!buffer.found) begin
            exc = req.rd ? RD_REFILL : WR_REFILL;
        end else if (!page.v) begin
            exc = req.rd ? RD_INVALID : WR_INVALID;
        end else if (req.wr && !page.d) begin
            exc = MODIFIED;
        end else begin
            valid = 1'b1;
        end
    end

    assign res = '{paddr: paddr, cached: cached, valid: valid, exc: exc};

endmodule

/* tlbArray.sv */
// 8-entry joint TLB
// indexed write port, combinational search by VPN2 and ASID

`timescale 1ns/1ns
`include "mmu_consts.svh"

module tlbArray (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    we,
    input  logic [`TLB_INDEX_W-1:0] wIndex,
    input  tlbTypesPkg::tlbEntryT   wEntry,
    input  logic [7:0]              asid,
    input  logic [18:0]             searchVpn2,
    output tlbTypesPkg::tlbEntryT   searchEntry,
    output logic                    searchFound
);
    import tlbTypesPkg::*;

    tlbEntryT                entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] hit;

    // software write port
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[wIndex] <= wEntry;
        end
    end

    // per entry match
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit[i] = (entries[i].vpn2 == searchVpn2)
                     && (entries[i].g || (entries[i].asid == asid));
        end
    end

    // Walk from the top so the lowest matching index is the one left.
    always_comb begin
        searchFound = 1'b0;
        searchEntry = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                searchFound = 1'b1;
                searchEntry = entries[i];
            end
        end
    end

endmodule

/* memAccessPkg.sv */
// access request, TLB exception codes and translation result

package memAccessPkg;

    typedef struct packed {
        logic               rd;     // load strobe
        logic               wr;     // store strobe
        tlbTypesPkg::vaddrU vaddr;
    } memReqT;

    typedef enum logic [2:0] {
        NONE       = 3'd0,
        RD_REFILL  = 3'd1,
        WR_REFILL  = 3'd2,
        RD_INVALID = 3'd3,
        WR_INVALID = 3'd4,
        MODIFIED   = 3'd5
    } tlbExcE;

    // level-style result, read in the same cycle as the request
    typedef struct packed {
        logic [31:0] paddr;
        logic        cached;
        logic        valid;
        tlbExcE      exc;
    } xlateResT;

endpackage

/* tlbTypesPkg.sv */
// joint TLB entry, buffered entry and the virtual address union

package tlbTypesPkg;

    // one page of an even/odd pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;  // cache attribute
        logic        d;  // dirty, page writable
        logic        v;  // valid
    } pageAttrT;

    typedef struct packed {
        logic [18:0]         vpn2;
        logic [7:0]          asid;
        logic                g;     // global, ignores asid
        pageAttrT [1:0]      page;  // index 0 even, 1 odd
    } tlbEntryT;

    typedef struct packed {
        tlbEntryT entry;
        logic     found;  // last search hit the joint TLB
    } bufEntryT;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;     // selects odd page
        logic [11:0] offset;
    } pageViewT;

    typedef struct packed {
        logic [2:0]  seg;   // kseg0 = 100, kseg1 = 101
        logic [28:0] rest;
    } segViewT;

    typedef union packed {
        pageViewT pageView;
        segViewT  segView;
    } vaddrU;

endpackage

/* mmu_consts.svh */
// joint TLB size and write index width
// unmapped segment bounds, cacheable attribute code, page offset width

`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// joint TLB
`define TLB_ENTRIES        8
`define TLB_INDEX_W        3

// segment bounds
`define KSEG0_BASE         32'h8000_0000
`define KSEG1_BASE         32'hA000_0000
`define KSEG2_BASE         32'hC000_0000

// page attribute code for cacheable, noncoherent
`define CACHE_ATTR_CACHED  3'b011

// 4 KB pages
`define PAGE_OFFSET_W      12

`endif
